// File: logic/lsu_pkg.sv
// Load/store operation types
package lsu_pkg;

    // Operation selector, {store, funct3} of the RV64 load/store opcodes
    typedef enum logic [3:0] {
        LB  = 4'b0_000,
        LH  = 4'b0_001,
        LW  = 4'b0_010,
        LD  = 4'b0_011,
        LBU = 4'b0_100,
        LHU = 4'b0_101,
        LWU = 4'b0_110,
        SB  = 4'b1_000,
        SH  = 4'b1_001,
        SW  = 4'b1_010,
        SD  = 4'b1_011
    } ls_sel_e;
    // 4'b0_111 and 4'b1_1xx are illegal

    // Access size, matches funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } ls_size_e;

endpackage

// File: logic/bus_pkg.sv
// Data bus vector types
package bus_pkg;

    // One doubleword of the data memory
    typedef logic [63:0] data_t;

    // One bit per byte lane
    typedef logic [7:0]  mask_t;

    // Integer register index
    typedef logic [4:0]  reg_addr_t;

endpackage

// File: logic/ls_decode.sv
// Load/store operation decoder
`timescale 1ns/1ns

module ls_decode
    import lsu_pkg::*;
(
    input  ls_sel_e    sel_i,
    input  logic [2:0] addr_lo_i,
    output logic       is_store_o,
    output logic       is_load_o,
    output ls_size_e   size_o,
    output logic       signed_o,
    output logic       misalign_o
);

    logic illegal;
    logic unaligned;

    always_comb begin
        is_store_o = 1'b0;
        is_load_o  = 1'b0;
        size_o     = SIZE_B;
        signed_o   = 1'b0;
        illegal    = 1'b0;
        case (sel_i)
            LB:  begin is_load_o = 1'b1; size_o = SIZE_B; signed_o = 1'b1; end
            LH:  begin is_load_o = 1'b1; size_o = SIZE_H; signed_o = 1'b1; end
            LW:  begin is_load_o = 1'b1; size_o = SIZE_W; signed_o = 1'b1; end
            LD:  begin is_load_o = 1'b1; size_o = SIZE_D; end
            LBU: begin is_load_o = 1'b1; size_o = SIZE_B; end
            LHU: begin is_load_o = 1'b1; size_o = SIZE_H; end
            LWU: begin is_load_o = 1'b1; size_o = SIZE_W; end
            SB:  begin is_store_o = 1'b1; size_o = SIZE_B; end
            SH:  begin is_store_o = 1'b1; size_o = SIZE_H; end
            SW:  begin is_store_o = 1'b1; size_o = SIZE_W; end
            SD:  begin is_store_o = 1'b1; size_o = SIZE_D; end
            default: begin
                illegal = 1'b1;    // Unused encoding
            end
        endcase
    end

    // Natural alignment per access size
    always_comb begin
        case (size_o)
            SIZE_B:  unaligned = 1'b0;
            SIZE_H:  unaligned = addr_lo_i[0];
            SIZE_W:  unaligned = |addr_lo_i[1:0];
            default: unaligned = |addr_lo_i;
        endcase
    end

    // Illegal ops take the error path too
    assign misalign_o = illegal | unaligned;

endmodule

// File: logic/store_align.sv
// Store byte-lane alignment
`timescale 1ns/1ns

module store_align
    import lsu_pkg::*;
    import bus_pkg::*;
(
    input  ls_size_e   size_i,
    input  logic [2:0] addr_lo_i,
    input  data_t      wdata_i,
    output data_t      lane_data_o,
    output mask_t      lane_mask_o
);

    logic [1:0] half_sel;
    logic       word_sel;
    data_t      sb_data;
    data_t      sh_data;
    data_t      sw_data;
    mask_t      sb_mask;
    mask_t      sh_mask;
    mask_t      sw_mask;

    assign half_sel = addr_lo_i[2:1];
    assign word_sel = addr_lo_i[2];

    // Byte store, one lane per address
    always_comb begin
        sb_data = data_t'(wdata_i[7:0]) << {addr_lo_i, 3'b000};
        sb_mask = mask_t'(1) << addr_lo_i;
    end

    // Halfword store
    always_comb begin
        case (half_sel)
            2'b00: begin
                sh_data = {48'd0, wdata_i[15:0]};
                sh_mask = 8'b0000_0011;
            end
            2'b01: begin
                sh_data = {32'd0, wdata_i[15:0], 16'd0};
                sh_mask = 8'b0000_1100;
            end
            2'b10: begin
                sh_data = {16'd0, wdata_i[15:0], 32'd0};
                sh_mask = 8'b0011_0000;
            end
            default: begin
                sh_data = {wdata_i[15:0], 48'd0};
                sh_mask = 8'b1100_0000;
            end
        endcase
    end

    // Word store, lower or upper half
    always_comb begin
        if (word_sel) begin
            sw_data = {wdata_i[31:0], 32'd0};
            sw_mask = 8'b1111_0000;
        end else begin
            sw_data = {32'd0, wdata_i[31:0]};
            sw_mask = 8'b0000_1111;
        end
    end

    always_comb begin
        case (size_i)
            SIZE_B: begin
                lane_data_o = sb_data;
                lane_mask_o = sb_mask;
            end
            SIZE_H: begin
                lane_data_o = sh_data;
                lane_mask_o = sh_mask;
            end
            SIZE_W: begin
                lane_data_o = sw_data;
                lane_mask_o = sw_mask;
            end
            default: begin
                lane_data_o = wdata_i;    // Whole doubleword
                lane_mask_o = 8'hff;
            end
        endcase
    end

endmodule

// File: logic/mem_port.sv
// Load/store handshake sequencer
`timescale 1ns/1ns

module mem_port
    import lsu_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              op_req_i,
    input  ls_sel_e           op_sel_i,
    input  logic [ADDR_W-1:0] op_addr_i,
    input  data_t             op_wdata_i,
    input  reg_addr_t         op_rd_i,
    input  logic              is_load_i,
    input  logic              is_store_i,
    input  logic              misalign_i,
    input  data_t             lane_data_i,
    input  mask_t             lane_mask_i,
    input  data_t             load_data_i,
    input  logic              mem_ack_i,
    input  data_t             mem_rdata_i,
    output ls_sel_e           sel_o,
    output logic [2:0]        addr_lo_o,
    output data_t             wdata_o,
    output logic              op_ack_o,
    output data_t             res_data_o,
    output logic              res_wen_o,
    output logic              res_err_o,
    output reg_addr_t         res_rd_o,
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic              mem_we_o,
    output data_t             mem_wdata_o,
    output mask_t             mem_wmask_o,
    output data_t             rdata_o
);

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT_LOW,
        ACK,
        ERR
    } state_e;

    state_e            state_q;
    logic              req_q;
    ls_sel_e           sel_q;
    logic [ADDR_W-1:0] addr_q;
    data_t             wdata_q;
    reg_addr_t         rd_q;
    data_t             rdata_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (op_req_i) state_q <= REQ;
                end
                REQ: begin
                    if (misalign_i) begin
                        state_q <= ERR;    // Never reaches memory
                    end else if (!req_q) begin
                        req_q <= 1'b1;
                    end else if (mem_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    if (!mem_ack_i) state_q <= ACK;
                end
                ACK, ERR: begin
                    if (!op_req_i) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Operation fields and read word
    always_ff @(posedge clk) begin
        if (state_q == IDLE && op_req_i) begin
            sel_q   <= op_sel_i;
            addr_q  <= op_addr_i;
            wdata_q <= op_wdata_i;
            rd_q    <= op_rd_i;
        end
        if (state_q == REQ && req_q && mem_ack_i) rdata_q <= mem_rdata_i;
    end

    assign sel_o     = sel_q;
    assign addr_lo_o = addr_q[2:0];
    assign wdata_o   = wdata_q;
    assign rdata_o   = rdata_q;

    assign mem_req_o   = req_q;
    assign mem_addr_o  = {addr_q[ADDR_W-1:3], 3'b000};    // Doubleword address
    assign mem_we_o    = is_store_i;
    assign mem_wdata_o = lane_data_i;
    assign mem_wmask_o = is_store_i ? lane_mask_i : '0;

    assign op_ack_o   = (state_q == ACK) || (state_q == ERR);
    assign res_err_o  = (state_q == ERR);
    assign res_wen_o  = (state_q == ACK) && is_load_i && (rd_q != '0);
    assign res_data_o = is_load_i ? load_data_i : '0;
    assign res_rd_o   = rd_q;

endmodule

// File: logic/load_extract.sv
// Load lane select and extension
`timescale 1ns/1ns

module load_extract
    import lsu_pkg::*;
    import bus_pkg::*;
(
    input  ls_size_e   size_i,
    input  logic       signed_i,
    input  logic [2:0] addr_lo_i,
    input  data_t      rdata_i,
    output data_t      load_data_o
);

    logic [7:0]  data_byte;
    logic [15:0] data_half;
    logic [31:0] data_word;

    // Addressed byte
    always_comb begin
        case (addr_lo_i)
            3'd0:    data_byte = rdata_i[7:0];
            3'd1:    data_byte = rdata_i[15:8];
            3'd2:    data_byte = rdata_i[23:16];
            3'd3:    data_byte = rdata_i[31:24];
            3'd4:    data_byte = rdata_i[39:32];
            3'd5:    data_byte = rdata_i[47:40];
            3'd6:    data_byte = rdata_i[55:48];
            default: data_byte = rdata_i[63:56];
        endcase
    end

    always_comb begin
        case (addr_lo_i[2:1])
            2'd0:    data_half = rdata_i[15:0];
            2'd1:    data_half = rdata_i[31:16];
            2'd2:    data_half = rdata_i[47:32];
            default: data_half = rdata_i[63:48];
        endcase
    end

    assign data_word = addr_lo_i[2] ? rdata_i[63:32] : rdata_i[31:0];

    always_comb begin
        case (size_i)
            SIZE_B:  load_data_o = {{56{signed_i & data_byte[7]}}, data_byte};
            SIZE_H:  load_data_o = {{48{signed_i & data_half[15]}}, data_half};
            SIZE_W:  load_data_o = {{32{signed_i & data_word[31]}}, data_word};
            default: load_data_o = rdata_i;
        endcase
    end

endmodule

// File: logic/lsu_top.sv
// Load/store unit top
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              op_req_i,
    input  ls_sel_e           op_sel_i,
    input  logic [ADDR_W-1:0] op_addr_i,
    input  data_t             op_wdata_i,
    input  reg_addr_t         op_rd_i,
    output logic              op_ack_o,
    output data_t             res_data_o,
    output logic              res_wen_o,
    output reg_addr_t         res_rd_o,
    output logic              res_err_o,
    output logic              mem_req_o,
    input  logic              mem_ack_i,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic              mem_we_o,
    output data_t             mem_wdata_o,
    output mask_t             mem_wmask_o,
    input  data_t             mem_rdata_i
);

    ls_sel_e    sel;
    logic [2:0] addr_lo;
    data_t      wdata;
    logic       is_load;
    logic       is_store;
    ls_size_e   size;
    logic       signed_ld;
    logic       misalign;
    data_t      lane_data;
    mask_t      lane_mask;
    data_t      rdata;
    data_t      load_data;

    ls_decode u_decode (
        .sel_i      (sel),
        .addr_lo_i  (addr_lo),
        .is_store_o (is_store),
        .is_load_o  (is_load),
        .size_o     (size),
        .signed_o   (signed_ld),
        .misalign_o (misalign)
    );

    store_align u_align (
        .size_i      (size),
        .addr_lo_i   (addr_lo),
        .wdata_i     (wdata),
        .lane_data_o (lane_data),
        .lane_mask_o (lane_mask)
    );

    mem_port #(
        .ADDR_W (ADDR_W)
    ) u_port (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .op_req_i    (op_req_i),
        .op_sel_i    (op_sel_i),
        .op_addr_i   (op_addr_i),
        .op_wdata_i  (op_wdata_i),
        .op_rd_i     (op_rd_i),
        .is_load_i   (is_load),
        .is_store_i  (is_store),
        .misalign_i  (misalign),
        .lane_data_i (lane_data),
        .lane_mask_i (lane_mask),
        .load_data_i (load_data),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .sel_o       (sel),
        .addr_lo_o   (addr_lo),
        .wdata_o     (wdata),
        .op_ack_o    (op_ack_o),
        .res_data_o  (res_data_o),
        .res_wen_o   (res_wen_o),
        .res_err_o   (res_err_o),
        .res_rd_o    (res_rd_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_we_o    (mem_we_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wmask_o (mem_wmask_o),
        .rdata_o     (rdata)
    );

    load_extract u_extract (
        .size_i      (size),
        .signed_i    (signed_ld),
        .addr_lo_i   (addr_lo),
        .rdata_i     (rdata),
        .load_data_o (load_data)
    );

endmodule

// File: verification/tb_mem_model.sv
// Data memory responder
`timescale 1ns/1ns

module tb_mem_model
    import bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              mem_req_i,
    input  logic [ADDR_W-1:0] mem_addr_i,
    input  logic              mem_we_i,
    input  data_t             mem_wdata_i,
    input  mask_t             mem_wmask_i,
    input  logic [1:0]        ack_delay_i,
    output logic              mem_ack_o,
    output data_t             mem_rdata_o
);

    data_t      mem [256];
    logic [1:0] wait_q;
    logic [7:0] idx;
    logic       fire;

    assign idx         = mem_addr_i[10:3];    // Doubleword index
    assign fire        = mem_req_i && !mem_ack_o && (wait_q == ack_delay_i);
    assign mem_rdata_o = mem[idx];

    // Every byte depends on the whole index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = {8{8'(i)}} ^ 64'h0f1e_2d3c_4b5a_6978;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_ack_o <= 1'b0;
            wait_q    <= '0;
        end else if (fire) begin
            mem_ack_o <= 1'b1;
            wait_q    <= '0;
        end else if (mem_req_i && !mem_ack_o) begin
            wait_q <= wait_q + 2'd1;    // Still delaying
        end else if (!mem_req_i && mem_ack_o) begin
            mem_ack_o <= 1'b0;
        end
    end

    // Masked write on the acknowledge edge
    always @(posedge clk) begin
        if (fire && mem_we_i) begin
            for (int k = 0; k < 8; k++) begin
                if (mem_wmask_i[k]) mem[idx][8*k +: 8] <= mem_wdata_i[8*k +: 8];
            end
        end
    end

endmodule

// File: verification/tb_lsu.sv
// Load/store unit testbench
`timescale 1ns/1ns

module tb_lsu
    import lsu_pkg::*;
    import bus_pkg::*;
();

    localparam int ADDR_W       = 32;
    localparam int NUM_OPS      = 200;
    localparam int RESET_CYCLES = 3;
    localparam int CYCLE_LIMIT  = NUM_OPS * 16 + RESET_CYCLES;

    logic              clk;
    logic              arst_n;
    logic              op_req;
    ls_sel_e           op_sel;
    logic [ADDR_W-1:0] op_addr;
    data_t             op_wdata;
    reg_addr_t         op_rd;
    logic              op_ack;
    data_t             res_data;
    logic              res_wen;
    reg_addr_t         res_rd;
    logic              res_err;
    logic              mem_req;
    logic              mem_ack;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_we;
    data_t             mem_wdata;
    mask_t             mem_wmask;
    data_t             mem_rdata;
    logic [1:0]        ack_delay;

    data_t             sb [256];    // Scoreboard copy of memory
    logic [31:0]       lfsr_q = 32'he019;
    int                cycles = 0;
    int                req_count = 0;
    logic              prev_req = 1'b0;
    logic              prev_ack = 1'b0;
    logic              prev_op_req = 1'b0;
    logic              prev_op_ack = 1'b0;
    logic [ADDR_W-1:0] cur_addr = '0;
    data_t             cur_wdata = '0;
    logic              cur_store = 1'b0;
    logic [3:0]        cur_bytes = 4'd1;
    logic [2:0]        cur_off = 3'd0;

    lsu_top u_dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .op_req_i    (op_req),
        .op_sel_i    (op_sel),
        .op_addr_i   (op_addr),
        .op_wdata_i  (op_wdata),
        .op_rd_i     (op_rd),
        .op_ack_o    (op_ack),
        .res_data_o  (res_data),
        .res_wen_o   (res_wen),
        .res_rd_o    (res_rd),
        .res_err_o   (res_err),
        .mem_req_o   (mem_req),
        .mem_ack_i   (mem_ack),
        .mem_addr_o  (mem_addr),
        .mem_we_o    (mem_we),
        .mem_wdata_o (mem_wdata),
        .mem_wmask_o (mem_wmask),
        .mem_rdata_i (mem_rdata)
    );

    tb_mem_model #(
        .ADDR_W (ADDR_W)
    ) u_mem (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_we_i    (mem_we),
        .mem_wdata_i (mem_wdata),
        .mem_wmask_i (mem_wmask),
        .ack_delay_i (ack_delay),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata)
    );

    always #20 clk = ~clk;

    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];    // x^32+x^22+x^2+x+1
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    // Loads 0..6, stores 8..11
    function automatic logic sel_legal(logic [3:0] s);
        return s[3] ? !s[2] : (s[2:0] != 3'b111);
    endfunction

    function automatic mask_t lane_mask(logic [3:0] n, logic [2:0] off);
        logic [8:0] ones;
        ones = (9'd1 << n) - 9'd1;
        return ones[7:0] << off;
    endfunction

    function automatic data_t mask_bits(mask_t m);
        data_t b;
        for (int k = 0; k < 8; k++) b[8*k +: 8] = {8{m[k]}};
        return b;
    endfunction

    function automatic data_t load_value(data_t word, logic [3:0] n, logic [2:0] off,
                                         logic sgn);
        data_t v;
        data_t keep;
        keep = (64'd1 << {n, 3'b000}) - 64'd1;    // All ones for a double
        v    = (word >> {off, 3'b000}) & keep;
        if (sgn && v[8*n-1]) v = v | ~keep;
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input data_t got, input data_t exp);
        assert (got === exp) else
            fail_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) fail_run($sformatf("Timeout after %0d cycles", cycles));
    end

    // Handshake and bus monitor
    always @(negedge clk) begin : monitor
        mask_t exp_mask;
        if (arst_n) begin
            check_eq("mem_addr_o[2:0]", 64'(mem_addr[2:0]), 64'd0);
            if (mem_req) begin
                check_eq("mem_addr_o[31:3]", 64'(mem_addr[ADDR_W-1:3]),
                         64'(cur_addr[ADDR_W-1:3]));
                check_eq("mem_we_o", 64'(mem_we), 64'(cur_store));
            end
            if (mem_req && mem_we) begin
                exp_mask = lane_mask(cur_bytes, cur_off);
                check_eq("mem_wmask_o", 64'(mem_wmask), 64'(exp_mask));
                check_eq("mem_wdata_o", mem_wdata & mask_bits(exp_mask),
                         (cur_wdata << {cur_off, 3'b000}) & mask_bits(exp_mask));
            end
            if (mem_req && !prev_req) begin
                assert (!mem_ack) else fail_run("New memory request while mem_ack_i is high");
                req_count = req_count + 1;
            end
            if (!mem_req && prev_req)
                assert (prev_ack) else fail_run("mem_req_o dropped before mem_ack_i rose");
            if (op_ack && !prev_op_ack)
                assert (op_req) else fail_run("op_ack_o rose while op_req_i was low");
            if (!op_ack && prev_op_ack)
                assert (!prev_op_req) else fail_run("op_ack_o fell before op_req_i fell");
        end
        prev_req    = mem_req;
        prev_ack    = mem_ack;
        prev_op_req = op_req;
        prev_op_ack = op_ack;
    end

    task automatic run_op(input logic [3:0] sel, input logic [ADDR_W-1:0] addr,
                          input data_t wdata, input reg_addr_t rd, input logic [1:0] dly);
        logic [3:0] n;
        logic       ok;
        logic [7:0] idx;
        data_t      bits;
        n         = 4'd1 << sel[1:0];
        ok        = sel_legal(sel) && ((addr[2:0] & 3'(n - 4'd1)) == 3'd0);
        idx       = addr[10:3];
        cur_addr  = addr;
        cur_wdata = wdata;
        cur_store = sel[3];
        cur_bytes = n;
        cur_off   = addr[2:0];
        req_count = 0;
        @(posedge clk);
        op_req    <= 1'b1;
        op_sel    <= ls_sel_e'(sel);
        op_addr   <= addr;
        op_wdata  <= wdata;
        op_rd     <= rd;
        ack_delay <= dly;
        @(negedge clk);
        while (!op_ack) @(negedge clk);
        check_eq("res_err_o", 64'(res_err), 64'(!ok));
        check_eq("res_rd_o", 64'(res_rd), 64'(rd));
        if (!ok) begin
            check_eq("res_wen_o", 64'(res_wen), 64'd0);    // Error path writes nothing
        end else if (sel[3]) begin
            bits    = mask_bits(lane_mask(n, addr[2:0]));
            sb[idx] = (sb[idx] & ~bits) | ((wdata << {addr[2:0], 3'b000}) & bits);
            check_eq("res_wen_o", 64'(res_wen), 64'd0);
            check_eq("res_data_o", res_data, 64'd0);
        end else begin
            check_eq("res_data_o", res_data, load_value(sb[idx], n, addr[2:0], !sel[2]));
            check_eq("res_wen_o", 64'(res_wen), 64'(rd != '0));
        end
        @(posedge clk);
        op_req <= 1'b0;
        @(negedge clk);
        while (op_ack) @(negedge clk);
        check_eq("mem_req_o count", 64'(req_count), 64'(ok));
        check_eq("memory word", u_mem.mem[idx], sb[idx]);
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  sel;
        logic [3:0]  n;
        logic [2:0]  lo;
        logic [2:0]  widx;
        logic [20:0] hi;
        data_t       wdata;
        reg_addr_t   rd;
        logic [1:0]  dly;
        clk       = 1'b0;
        arst_n    = 1'b0;
        op_req    = 1'b0;
        op_sel    = LB;
        op_addr   = '0;
        op_wdata  = '0;
        op_rd     = '0;
        ack_delay = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!op_ack && !mem_req) else fail_run("op_ack_o or mem_req_o high after reset");
        for (int i = 0; i < 256; i++) sb[8'(i)] = u_mem.mem[8'(i)];
        for (int i = 0; i < NUM_OPS; i++) begin
            r     = rand_bits(4);
            sel   = r[3:0];
            n     = 4'd1 << sel[1:0];
            r     = rand_bits(21);
            hi    = r[20:0];
            r     = rand_bits(3);
            widx  = r[2:0];    // Small window so loads hit earlier stores
            r     = rand_bits(3);
            lo    = r[2:0];
            r     = rand_bits(1);
            if (r[0]) lo = lo & ~3'(n - 4'd1);
            r     = rand_bits(32);
            wdata = {r, 32'd0};
            r     = rand_bits(32);
            wdata = wdata | 64'(r);
            r     = rand_bits(5);
            rd    = r[4:0];
            r     = rand_bits(2);
            if (r[1:0] == 2'd0) rd = '0;    // Some operations target x0
            r     = rand_bits(2);
            dly   = r[1:0];
            run_op(sel, {hi, 5'd0, widx, lo}, wdata, rd, dly);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: all.f
logic/lsu_pkg.sv
logic/bus_pkg.sv
logic/ls_decode.sv
logic/store_align.sv
logic/mem_port.sv
logic/load_extract.sv
logic/lsu_top.sv
verification/tb_mem_model.sv
verification/tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: sim clean

# Pass only when the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
